// File: src.f
+incdir+hdl
+incdir+tests
hdl/axi4s_pkg.sv
hdl/axi4l_pkg.sv
hdl/axi4s_intf.sv
hdl/axi4s_full_pipe.sv
hdl/axi4s_drop.sv
hdl/axi4s_probe.sv
hdl/axi4l_drop_regs.sv
hdl/axi4s_drop_top.sv
tests/tb_axi4s_drop.sv

// File: tests/tb_axi4s_drop_table.svh
/*
 * Stimulus rows for the packet drop testbench.
 * Included inside the testbench module after stim_row_t is declared.
 */

`ifndef TB_AXI4S_DROP_TABLE_SVH
`define TB_AXI4S_DROP_TABLE_SVH

localparam int N_ROWS   = 17;
// random out_ready gaps start from this row.
localparam int RAND_ROW = 11;

// columns are tdata, tkeep, tlast, tuser, drop_pkt, out_ready hold-off cycles.
stim_row_t stim_rows [N_ROWS] = '{
   '{32'h1000_0001, 4'hf, 1'b0, 4'h1, 1'b0, 4'd0},
   '{32'h1000_0002, 4'hf, 1'b0, 4'h1, 1'b0, 4'd0},
   '{32'h1000_0003, 4'h3, 1'b1, 4'h1, 1'b0, 4'd2},
   '{32'h2000_0001, 4'hf, 1'b0, 4'h2, 1'b0, 4'd0},
   '{32'h2000_0002, 4'hf, 1'b0, 4'h2, 1'b1, 4'd3},
   '{32'h2000_0003, 4'hf, 1'b0, 4'h2, 1'b0, 4'd3},
   '{32'h2000_0004, 4'h7, 1'b1, 4'h2, 1'b0, 4'd0},
   '{32'h3000_0001, 4'hf, 1'b0, 4'h3, 1'b0, 4'd0},
   '{32'h3000_0002, 4'h1, 1'b1, 4'h3, 1'b0, 4'd0},
   '{32'h4000_0001, 4'hf, 1'b0, 4'h4, 1'b0, 4'd0},
   '{32'h4000_0002, 4'h3, 1'b1, 4'h4, 1'b1, 4'd0},
   '{32'h5000_0001, 4'hf, 1'b1, 4'h5, 1'b1, 4'd2},
   '{32'h6000_0001, 4'hf, 1'b0, 4'h6, 1'b0, 4'd0},
   '{32'h6000_0002, 4'hf, 1'b0, 4'h6, 1'b0, 4'd1},
   '{32'h6000_0003, 4'hf, 1'b0, 4'h6, 1'b0, 4'd0},
   '{32'h6000_0004, 4'hc, 1'b1, 4'h6, 1'b0, 4'd0},
   '{32'h7000_0001, 4'hf, 1'b1, 4'h7, 1'b0, 4'd0}
};

`endif

// File: tests/tb_axi4s_drop.sv
/*
 * Testbench for the packet drop stage.
 * Streams the table rows through the DUT, checks the output against a
 * model of the drop rule, then reads, clears and rereads the counters.
 */

`timescale 1ns/1ps

`include "axi4s_macros.svh"

module tb_axi4s_drop
   import axi4s_pkg::*;
   import axi4l_pkg::*;
();

   localparam int CLK_NS = 10;

   typedef struct packed {
      tdata_t     tdata;
      tkeep_t     tkeep;
      logic       tlast;
      tuser_t     tuser;
      logic       drop;
      logic [3:0] hold;
   } stim_row_t;

`include "tb_axi4s_drop_table.svh"

   localparam int WATCHDOG_CYCLES = N_ROWS * 20 + 200;

   logic                    axi4s_in;
   logic                    rst;
   logic                    in_tvalid;
   logic                    in_tready;
   tdata_t                  in_tdata;
   tkeep_t                  in_tkeep;
   logic                    in_tlast;
   tuser_t                  in_tuser;
   logic                    out_tvalid;
   logic                    out_tready;
   tdata_t                  out_tdata;
   tkeep_t                  out_tkeep;
   logic                    out_tlast;
   tuser_t                  out_tuser;
   logic                    drop_pkt;
   logic                    awvalid;
   logic [`AXIL_ADDR_W-1:0] awaddr;
   logic                    wvalid;
   axil_data_t              wdata;
   logic                    bready;
   logic                    arvalid;
   logic [`AXIL_ADDR_W-1:0] araddr;
   logic                    rready;
   logic                    awready;
   logic                    wready;
   logic                    bvalid;
   axil_resp_e              bresp;
   logic                    arready;
   logic                    rvalid;
   axil_data_t              rdata;
   axil_resp_e              rresp;

   // reference model state.
   axi4s_word_t exp_q [$];
   byte_cnt_t   exp_pkts;
   byte_cnt_t   exp_bytes;
   logic        model_latch;
   int          cur_row;
   integer      seed = 32'h464dfa5b;

   axi4s_drop_top i_dut (.*);

   initial begin
      axi4s_in = 1'b0;
      forever #(CLK_NS / 2) axi4s_in = ~axi4s_in;
   end

   // --------------------------------------------------
   // checks.
   // --------------------------------------------------
   task automatic stop_on_error();
      $display("Errors found");
      $fatal(1, "simulation stopped at first failure.");
   endtask

   task automatic check_word(input string name, input axi4s_word_t exp,
                             input axi4s_word_t act);
      if (act !== exp) begin
         $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_cnt(input string name, input byte_cnt_t exp, input byte_cnt_t act);
      if (act !== exp) begin
         $display("ERR t=%0t %s expected %0d actual %0d", $time, name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_resp(input string name, input axil_resp_e exp,
                             input axil_resp_e act);
      if (act !== exp) begin
         $display("ERR t=%0t %s expected %s actual %s", $time, name, exp.name(), act.name());
         stop_on_error();
      end
   endtask

   function automatic byte_cnt_t count_keep(input tkeep_t keep);
      byte_cnt_t n;
      n = '0;
      for (int b = 0; b < `AXI4S_DATA_BYTES; b++)
         n = n + keep[b];
      return n;
   endfunction

   // --------------------------------------------------
   // stream model and output check at the falling edge.
   // --------------------------------------------------
   initial begin : stream_monitor
      axi4s_word_t act;
      logic        drop;
      forever begin
         @(negedge axi4s_in);
         if (!rst) begin
            if (out_tvalid && out_tready) begin
               act = {out_tdata, out_tkeep, out_tlast, out_tuser};
               if (exp_q.size() == 0) begin
                  $display("output word %h appeared with no word expected", act);
                  stop_on_error();
               end else begin
                  check_word("out_word", exp_q.pop_front(), act);
               end
            end
            drop = drop_pkt || model_latch;
            if (in_tvalid && drop && !in_tready) begin
               $display("dropped word at t=%0t was held instead of drained", $time);
               stop_on_error();
            end
            if (in_tvalid && in_tready) begin
               if (drop) begin
                  exp_bytes = exp_bytes + count_keep(in_tkeep);
                  if (in_tlast)
                     exp_pkts = exp_pkts + 1;
               end else begin
                  exp_q.push_back({in_tdata, in_tkeep, in_tlast, in_tuser});
               end
            end
            // end of packet clears before a new request sets.
            if (in_tvalid && in_tready && in_tlast)
               model_latch = 1'b0;
            else if (drop_pkt)
               model_latch = 1'b1;
         end
      end
   end

   // out_ready follows the row hold-off first and random gaps in the later rows.
   initial begin : ready_gen
      int          seen_row;
      int          hold_left;
      logic        nxt;
      logic [31:0] r;
      seen_row  = -1;
      hold_left = 0;
      forever begin
         @(negedge axi4s_in);
         if (cur_row != seen_row) begin
            seen_row  = cur_row;
            hold_left = stim_rows[cur_row].hold;
         end
         r = $random(seed);
         if (hold_left > 0) begin
            nxt       = 1'b0;
            hold_left = hold_left - 1;
         end else if (cur_row >= RAND_ROW) begin
            nxt = (r[1:0] != 2'b00);
         end else begin
            nxt = 1'b1;
         end
         @(posedge axi4s_in);
         #1;
         out_tready = nxt;
      end
   end

   initial begin : watchdog
      #(WATCHDOG_CYCLES * CLK_NS);
      $display("timeout, run did not finish within %0d cycles", WATCHDOG_CYCLES);
      stop_on_error();
   end

   // --------------------------------------------------
   // drivers.
   // --------------------------------------------------
   task automatic send_row(input int idx);
      cur_row   = idx;
      in_tvalid = 1'b1;
      in_tdata  = stim_rows[idx].tdata;
      in_tkeep  = stim_rows[idx].tkeep;
      in_tlast  = stim_rows[idx].tlast;
      in_tuser  = stim_rows[idx].tuser;
      drop_pkt  = stim_rows[idx].drop;
      do @(negedge axi4s_in); while (!in_tready);
      @(posedge axi4s_in);
      #1;
   endtask

   task automatic wait_drained();
      do @(negedge axi4s_in); while (exp_q.size() != 0 || out_tvalid);
      @(posedge axi4s_in);
      #1;
   endtask

   task automatic axil_write(input logic [`AXIL_ADDR_W-1:0] addr, input axil_data_t data,
                             output axil_resp_e resp);
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      bready  = 1'b1;
      do @(negedge axi4s_in); while (!awready);
      // address and data are taken in the same cycle.
      if (wready !== 1'b1) begin
         $display("ERR t=%0t wready expected 1 actual %b", $time, wready);
         stop_on_error();
      end
      @(posedge axi4s_in);
      #1;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      do @(negedge axi4s_in); while (!bvalid);
      resp = bresp;
      @(posedge axi4s_in);
      #1;
      bready = 1'b0;
   endtask

   task automatic axil_read(input logic [`AXIL_ADDR_W-1:0] addr, output axil_data_t data,
                            output axil_resp_e resp);
      araddr  = addr;
      arvalid = 1'b1;
      rready  = 1'b1;
      do @(negedge axi4s_in); while (!arready);
      @(posedge axi4s_in);
      #1;
      arvalid = 1'b0;
      do @(negedge axi4s_in); while (!rvalid);
      data = rdata;
      resp = rresp;
      @(posedge axi4s_in);
      #1;
      rready = 1'b0;
   endtask

   // --------------------------------------------------
   // main sequence.
   // --------------------------------------------------
   initial begin : main
      axil_data_t rd_data;
      axil_resp_e rd_resp;
      rst         = 1'b1;
      in_tvalid   = 1'b0;
      in_tdata    = '0;
      in_tkeep    = '0;
      in_tlast    = 1'b0;
      in_tuser    = '0;
      out_tready  = 1'b0;
      drop_pkt    = 1'b0;
      awvalid     = 1'b0;
      awaddr      = '0;
      wvalid      = 1'b0;
      wdata       = '0;
      bready      = 1'b0;
      arvalid     = 1'b0;
      araddr      = '0;
      rready      = 1'b0;
      cur_row     = -1;
      exp_pkts    = '0;
      exp_bytes   = '0;
      model_latch = 1'b0;
      repeat (2) @(posedge axi4s_in);
      #1;
      rst = 1'b0;
      if (out_tvalid !== 1'b0 || bvalid !== 1'b0 || rvalid !== 1'b0) begin
         $display("valid outputs not low after reset");
         stop_on_error();
      end

      for (int i = 0; i < N_ROWS; i++)
         send_row(i);
      in_tvalid = 1'b0;
      drop_pkt  = 1'b0;
      wait_drained();

      // counters against the model.
      axil_read(REG_DROP_PKTS, rd_data, rd_resp);
      check_resp("rresp", OKAY, rd_resp);
      check_cnt("pkt_cnt", exp_pkts, byte_cnt_t'(rd_data));
      axil_read(REG_DROP_BYTES, rd_data, rd_resp);
      check_resp("rresp", OKAY, rd_resp);
      check_cnt("byte_cnt", exp_bytes, byte_cnt_t'(rd_data));

      // clear, then both read back zero.
      axil_write(REG_CTRL, 32'h1, rd_resp);
      check_resp("bresp", OKAY, rd_resp);
      exp_pkts  = '0;
      exp_bytes = '0;
      axil_read(REG_DROP_PKTS, rd_data, rd_resp);
      check_cnt("pkt_cnt", exp_pkts, byte_cnt_t'(rd_data));
      axil_read(REG_DROP_BYTES, rd_data, rd_resp);
      check_cnt("byte_cnt", exp_bytes, byte_cnt_t'(rd_data));

      // unmapped offset.
      axil_read(4'hc, rd_data, rd_resp);
      check_resp("rresp", SLVERR, rd_resp);

      $display("No errors");
      $finish;
   end

endmodule

// File: hdl/axi4s_drop_top.sv
/*
 * Packet drop stage for the egress stream.
 * Filter, output skid buffer, drop statistics and their AXI4-Lite
 * register block, all on plain ports.
 */

`timescale 1ns/1ps

`include "axi4s_macros.svh"

module axi4s_drop_top
   import axi4s_pkg::*;
   import axi4l_pkg::*;
(
   input  logic                    axi4s_in,
   input  logic                    rst,
   input  logic                    in_tvalid,
   output logic                    in_tready,
   input  tdata_t                  in_tdata,
   input  tkeep_t                  in_tkeep,
   input  logic                    in_tlast,
   input  tuser_t                  in_tuser,
   output logic                    out_tvalid,
   input  logic                    out_tready,
   output tdata_t                  out_tdata,
   output tkeep_t                  out_tkeep,
   output logic                    out_tlast,
   output tuser_t                  out_tuser,
   input  logic                    drop_pkt,
   input  logic                    awvalid,
   input  logic [`AXIL_ADDR_W-1:0] awaddr,
   input  logic                    wvalid,
   input  axil_data_t              wdata,
   input  logic                    bready,
   input  logic                    arvalid,
   input  logic [`AXIL_ADDR_W-1:0] araddr,
   input  logic                    rready,
   output logic                    awready,
   output logic                    wready,
   output logic                    bvalid,
   output axil_resp_e              bresp,
   output logic                    arready,
   output logic                    rvalid,
   output axil_data_t              rdata,
   output axil_resp_e              rresp
);

   axi4s_intf in_if ();
   axi4s_intf filt_if ();
   axi4s_intf out_if ();

   logic      drop_beat;
   tkeep_t    drop_keep;
   logic      drop_last;
   logic      cnt_clear;
   byte_cnt_t pkt_cnt;
   byte_cnt_t byte_cnt;

   // --------------------------------------------------
   // stream ports onto the internal links.
   // --------------------------------------------------
   assign in_if.tvalid     = in_tvalid;
   assign in_if.word.tdata = in_tdata;
   assign in_if.word.tkeep = in_tkeep;
   assign in_if.word.tlast = in_tlast;
   assign in_if.word.tuser = in_tuser;
   assign in_tready        = in_if.tready;

   assign out_tvalid    = out_if.tvalid;
   assign out_tdata     = out_if.word.tdata;
   assign out_tkeep     = out_if.word.tkeep;
   assign out_tlast     = out_if.word.tlast;
   assign out_tuser     = out_if.word.tuser;
   assign out_if.tready = out_tready;

   // --------------------------------------------------
   // blocks.
   // --------------------------------------------------
   axi4s_drop i_drop (
      .in_if     (in_if),
      .filt_if   (filt_if),
      .drop_pkt  (drop_pkt),
      .drop_beat (drop_beat),
      .drop_keep (drop_keep),
      .drop_last (drop_last),
      .axi4s_in  (axi4s_in),
      .rst       (rst)
   );

   axi4s_full_pipe i_out_pipe (
      .axi4s_in (axi4s_in),
      .rst      (rst),
      .up_if    (filt_if),
      .dn_if    (out_if)
   );

   axi4s_probe i_probe (
      .axi4s_in  (axi4s_in),
      .rst       (rst),
      .drop_beat (drop_beat),
      .drop_keep (drop_keep),
      .drop_last (drop_last),
      .cnt_clear (cnt_clear),
      .pkt_cnt   (pkt_cnt),
      .byte_cnt  (byte_cnt)
   );

   axi4l_drop_regs i_regs (
      .axi4s_in  (axi4s_in),
      .rst       (rst),
      .awvalid   (awvalid),
      .awaddr    (awaddr),
      .wvalid    (wvalid),
      .wdata     (wdata),
      .bready    (bready),
      .arvalid   (arvalid),
      .araddr    (araddr),
      .rready    (rready),
      .awready   (awready),
      .wready    (wready),
      .bvalid    (bvalid),
      .bresp     (bresp),
      .arready   (arready),
      .rvalid    (rvalid),
      .rdata     (rdata),
      .rresp     (rresp),
      .cnt_clear (cnt_clear),
      .pkt_cnt   (pkt_cnt),
      .byte_cnt  (byte_cnt)
   );

endmodule

// File: hdl/axi4l_drop_regs.sv
/*
 * AXI4-Lite slave for the drop statistics.
 * Reads back the counters, a write of 1 to bit 0 of the control register
 * clears them. One transaction is handled at a time.
 */

`timescale 1ns/1ps

`include "axi4s_macros.svh"

module axi4l_drop_regs
   import axi4s_pkg::*;
   import axi4l_pkg::*;
(
   input  logic                    axi4s_in,
   input  logic                    rst,
   input  logic                    awvalid,
   input  logic [`AXIL_ADDR_W-1:0] awaddr,
   input  logic                    wvalid,
   input  axil_data_t              wdata,
   input  logic                    bready,
   input  logic                    arvalid,
   input  logic [`AXIL_ADDR_W-1:0] araddr,
   input  logic                    rready,
   output logic                    awready,
   output logic                    wready,
   output logic                    bvalid,
   output axil_resp_e              bresp,
   output logic                    arready,
   output logic                    rvalid,
   output axil_data_t              rdata,
   output axil_resp_e              rresp,
   output logic                    cnt_clear,
   input  byte_cnt_t               pkt_cnt,
   input  byte_cnt_t               byte_cnt
);

   typedef enum logic [1:0] {IDLE, WRESP, RRESP} state_e;

   state_e state;
   logic   wr_go;
   logic   rd_go;

   // writes win when both arrive together.
   assign wr_go   = (state == IDLE) && awvalid && wvalid;
   assign rd_go   = (state == IDLE) && arvalid && !(awvalid && wvalid);
   assign awready = wr_go;
   assign wready  = wr_go;
   assign arready = rd_go;
   assign bvalid  = (state == WRESP);
   assign rvalid  = (state == RRESP);

   // --------------------------------------------------
   // control FSM.
   // --------------------------------------------------
   always_ff @(posedge axi4s_in) begin
      if (rst) begin
         state     <= IDLE;
         cnt_clear <= 1'b0;
      end else begin
         cnt_clear <= 1'b0;
         case (state)
            IDLE: begin
               if (wr_go) begin
                  state     <= WRESP;
                  cnt_clear <= (awaddr == REG_CTRL) && wdata[0];
               end else if (rd_go) begin
                  state <= RRESP;
               end
            end
            WRESP:   if (bready) state <= IDLE;
            RRESP:   if (rready) state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   // --------------------------------------------------
   // response data.
   // --------------------------------------------------
   always_ff @(posedge axi4s_in) begin
      if (wr_go) begin
         case (awaddr)
            REG_DROP_PKTS, REG_DROP_BYTES, REG_CTRL: bresp <= OKAY;
            default:                                 bresp <= SLVERR;
         endcase
      end
      if (rd_go) begin
         rresp <= OKAY;
         case (araddr)
            REG_DROP_PKTS:  rdata <= pkt_cnt;
            REG_DROP_BYTES: rdata <= byte_cnt;
            REG_CTRL:       rdata <= '0;
            default: begin
               rdata <= '0;
               rresp <= SLVERR;
            end
         endcase
      end
   end

endmodule

// File: hdl/axi4s_probe.sv
/*
 * Drop statistics, counting dropped packets and dropped bytes.
 */

`timescale 1ns/1ps

module axi4s_probe
   import axi4s_pkg::*;
(
   input  logic      axi4s_in,
   input  logic      rst,
   input  logic      drop_beat,
   input  tkeep_t    drop_keep,
   input  logic      drop_last,
   input  logic      cnt_clear,
   output byte_cnt_t pkt_cnt,
   output byte_cnt_t byte_cnt
);

   byte_cnt_t beat_bytes;

   // valid bytes in the dropped beat.
   assign beat_bytes = byte_cnt_t'($countones(drop_keep));

   always_ff @(posedge axi4s_in) begin
      if (rst || cnt_clear) begin
         pkt_cnt  <= '0;
         byte_cnt <= '0;
      end else if (drop_beat) begin
         byte_cnt <= byte_cnt + beat_bytes;
         if (drop_last)
            pkt_cnt <= pkt_cnt + 1'b1;
      end
   end

endmodule

// File: hdl/axi4s_drop.sv
/*
 * Packet filter for the egress stream.
 * From drop_pkt through the end of the current packet every beat is
 * discarded, and each discarded beat is reported to the probe.
 */

`timescale 1ns/1ps

module axi4s_drop
   import axi4s_pkg::*;
(
   axi4s_intf.rx  in_if,
   axi4s_intf.tx  filt_if,
   input  logic   drop_pkt,
   output logic   drop_beat,
   output tkeep_t drop_keep,
   output logic   drop_last,
   input  logic   axi4s_in,
   input  logic   rst
);

   logic drop_latch;
   logic drop;
   logic in_take;

   assign in_take = in_if.tvalid && in_if.tready;

   // end of packet wins over a new request in the same cycle.
   always_ff @(posedge axi4s_in) begin
      if (rst)
         drop_latch <= 1'b0;
      else if (in_take && in_if.word.tlast)
         drop_latch <= 1'b0;
      else if (drop_pkt)
         drop_latch <= 1'b1;
   end

   assign drop = drop_pkt || drop_latch;

   // --------------------------------------------------
   // stream path.
   // --------------------------------------------------

   // dropped beats drain regardless of downstream back-pressure.
   assign in_if.tready   = filt_if.tready || drop;
   assign filt_if.tvalid = in_if.tvalid && !drop;
   assign filt_if.word   = in_if.word;

   // --------------------------------------------------
   // probe report.
   // --------------------------------------------------
   assign drop_beat = in_take && drop;
   assign drop_keep = in_if.word.tkeep;
   assign drop_last = in_if.word.tlast;

endmodule

// File: hdl/axi4s_full_pipe.sv
/*
 * Two-entry skid buffer for the stream.
 * Registers valid, ready and data while sustaining one beat per cycle.
 */

`timescale 1ns/1ps

module axi4s_full_pipe
   import axi4s_pkg::*;
(
   input logic   axi4s_in,
   input logic   rst,
   axi4s_intf.rx up_if,
   axi4s_intf.tx dn_if
);

   axi4s_word_t main_word;
   axi4s_word_t skid_word;
   logic        main_valid;
   logic        skid_valid;
   logic        up_take;
   logic        dn_take;

   // ready only depends on whether the spare entry is free.
   assign up_if.tready = !skid_valid;
   assign up_take      = up_if.tvalid && !skid_valid;
   assign dn_take      = main_valid && dn_if.tready;

   assign dn_if.tvalid = main_valid;
   assign dn_if.word   = main_word;

   // --------------------------------------------------
   // fill level.
   // --------------------------------------------------
   always_ff @(posedge axi4s_in) begin
      if (rst) begin
         main_valid <= 1'b0;
         skid_valid <= 1'b0;
      end else if (skid_valid) begin
         // full, so only the output side can move.
         if (dn_take)
            skid_valid <= 1'b0;
      end else if (up_take) begin
         main_valid <= 1'b1;
         if (main_valid && !dn_take)
            skid_valid <= 1'b1;
      end else if (dn_take) begin
         main_valid <= 1'b0;
      end
   end

   // --------------------------------------------------
   // payload.
   // --------------------------------------------------
   always_ff @(posedge axi4s_in) begin
      if (skid_valid) begin
         if (dn_take)
            main_word <= skid_word;
      end else if (up_take) begin
         if (main_valid && !dn_take)
            skid_word <= up_if.word;
         else
            main_word <= up_if.word;
      end
   end

endmodule

// File: hdl/axi4s_intf.sv
/*
 * AXI4-Stream link between blocks of the drop stage.
 * The tx side drives valid and the beat, the rx side drives ready.
 */

`timescale 1ns/1ps

interface axi4s_intf
   import axi4s_pkg::*;
();

   logic        tvalid;
   logic        tready;
   axi4s_word_t word;

   // sender side.
   modport tx (
      output tvalid,
      output word,
      input  tready
   );

   // receiver side.
   modport rx (
      input  tvalid,
      input  word,
      output tready
   );

endinterface

// File: hdl/axi4l_pkg.sv
/*
 * AXI4-Lite types for the drop statistics register block.
 */

`include "axi4s_macros.svh"

package axi4l_pkg;

   // register offsets.
   typedef enum logic [`AXIL_ADDR_W-1:0] {
      REG_DROP_PKTS  = 'h0,
      REG_DROP_BYTES = 'h4,
      REG_CTRL       = 'h8
   } drop_reg_e;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } axil_resp_e;

   typedef logic [`AXIL_DATA_W-1:0] axil_data_t;

endpackage

// File: hdl/axi4s_pkg.sv
/*
 * Stream types for the packet drop stage.
 * Shared by the stream interface, the filter, the probe and the testbench.
 */

`include "axi4s_macros.svh"

package axi4s_pkg;

   typedef logic [`AXI4S_DATA_BYTES*8-1:0] tdata_t;
   typedef logic [`AXI4S_DATA_BYTES-1:0]   tkeep_t;
   typedef logic [`AXI4S_TUSER_W-1:0]      tuser_t;

   // one stream beat, as held in the skid buffer.
   typedef struct packed {
      tdata_t tdata;
      tkeep_t tkeep;
      logic   tlast;
      tuser_t tuser;
   } axi4s_word_t;

   // drop statistics, wrap on overflow.
   typedef logic [31:0] byte_cnt_t;

endpackage

// File: hdl/axi4s_macros.svh
/*
 * Width parameters for the packet drop stage.
 * Included by the packages and by modules that size ports directly.
 */

`ifndef AXI4S_MACROS_SVH
`define AXI4S_MACROS_SVH

// stream side.
`define AXI4S_DATA_BYTES 4
`define AXI4S_TUSER_W    4

// register bus side.
`define AXIL_ADDR_W      4
`define AXIL_DATA_W      32

`endif
